/* Makefile */
# Verilator build of the five-stage core testbench
# override any variable on the command line, e.g. make run BUILD_DIR=out

VERILATOR ?= verilator
TOP ?= tb_core
BUILD_DIR ?= obj_dir
FILELIST ?= build.f
VFLAGS ?= --binary --timing --timescale 1ns/10ps

.PHONY: all compile run clean

all: run

# build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# exit status is nonzero when the testbench stops with $$fatal
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* build.f */
design/core_pkg.sv
design/register_file.sv
design/fetch_unit.sv
design/decode_unit.sv
design/execute_unit.sv
design/memory_unit.sv
design/writeback_unit.sv
design/npc_core.sv
sim/tb_core.sv

/* design/core_pkg.sv */
// shared widths, memory depths, RV64 opcode fields and ALU encodings imported by every core stage
package core_pkg;

	// ********************
	// widths and sizes
	// ********************
	localparam int XLEN = 64;
	localparam int ILEN = 32;
	localparam int NREG = 32;
	localparam int REG_AW = 5;
	// instruction memory in 32-bit words
	localparam int IMEM_DEPTH = 256;
	// data memory in 64-bit doublewords
	localparam int DMEM_DEPTH = 256;
	localparam logic [XLEN-1:0] RESET_PC = '0;

	// ********************
	// major opcodes
	// ********************
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;

	// funct3 / funct7 codes
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [2:0] F3_LD_SD = 3'b011;
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [6:0] F7_SUB = 7'b0100000;

	// execute operation and memory access kind
	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B} alu_op_t;
	typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_t;

endpackage

/* design/decode_unit.sv */
// decode stage with immediate extraction, register read, busy scoreboard and the id_ex register
`timescale 1ns/10ps

module decode_unit import core_pkg::*; (
	input logic clk,
	input logic rst,
	// from fetch
	input logic in_valid,
	output logic in_ready,
	input logic [XLEN-1:0] in_pc,
	input logic [ILEN-1:0] in_inst,
	// register file
	output logic [REG_AW-1:0] rs1_addr,
	input logic [XLEN-1:0] rs1_data,
	output logic [REG_AW-1:0] rs2_addr,
	input logic [XLEN-1:0] rs2_data,
	// writeback clears busy bits
	input logic wb_en,
	input logic [REG_AW-1:0] wb_rd,
	input logic flush,
	// to execute
	output logic out_valid,
	input logic out_ready,
	output logic [XLEN-1:0] out_pc,
	output logic [XLEN-1:0] out_src_a,
	output logic [XLEN-1:0] out_src_b,
	output logic [XLEN-1:0] out_imm,
	output logic [REG_AW-1:0] out_rd,
	output alu_op_t out_alu_op,
	output mem_op_t out_mem_op,
	output logic out_is_branch,
	output logic out_branch_ne,
	output logic out_is_jal,
	output logic out_use_imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [XLEN-1:0] imm;
	logic [REG_AW-1:0] dec_rd;
	alu_op_t alu_op;
	mem_op_t mem_op;
	logic is_branch, branch_ne, is_jal, use_imm;
	logic use_rs1, use_rs2;
	logic [NREG-1:0] busy;
	logic hazard, slot_free, issue;

	// ********************
	// fields and immediates
	// ********************
	assign opcode = in_inst[6:0];
	assign funct3 = in_inst[14:12];
	assign funct7 = in_inst[31:25];
	assign rs1_addr = in_inst[19:15];
	assign rs2_addr = in_inst[24:20];

	assign imm_i = {{(XLEN-12){in_inst[31]}}, in_inst[31:20]};
	assign imm_s = {{(XLEN-12){in_inst[31]}}, in_inst[31:25], in_inst[11:7]};
	assign imm_b = {{(XLEN-13){in_inst[31]}}, in_inst[31], in_inst[7], in_inst[30:25],
		in_inst[11:8], 1'b0};
	assign imm_u = {{(XLEN-32){in_inst[31]}}, in_inst[31:12], 12'b0};
	assign imm_j = {{(XLEN-21){in_inst[31]}}, in_inst[31], in_inst[19:12], in_inst[20],
		in_inst[30:21], 1'b0};

	// opcode map, anything unknown falls out as a no-op with rd 0
	always_comb begin
		dec_rd = '0;
		imm = imm_i;
		alu_op = ALU_ADD;
		mem_op = MEM_NONE;
		is_branch = 1'b0;
		branch_ne = 1'b0;
		is_jal = 1'b0;
		use_imm = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (opcode)
			OPC_OP_IMM: begin
				use_rs1 = 1'b1;
				use_imm = 1'b1;
				dec_rd = in_inst[11:7];
				case (funct3)
					F3_ADD: alu_op = ALU_ADD;
					F3_XOR: alu_op = ALU_XOR;
					F3_OR: alu_op = ALU_OR;
					F3_AND: alu_op = ALU_AND;
					default: begin
						dec_rd = '0;
						use_rs1 = 1'b0;
					end
				endcase
			end
			OPC_OP: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				dec_rd = in_inst[11:7];
				case (funct3)
					F3_ADD: alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
					F3_XOR: alu_op = ALU_XOR;
					F3_OR: alu_op = ALU_OR;
					F3_AND: alu_op = ALU_AND;
					default: begin
						dec_rd = '0;
						use_rs1 = 1'b0;
						use_rs2 = 1'b0;
					end
				endcase
			end
			OPC_LUI: begin
				// upper immediate straight through the alu
				dec_rd = in_inst[11:7];
				imm = imm_u;
				use_imm = 1'b1;
				alu_op = ALU_PASS_B;
			end
			OPC_LOAD: begin
				if (funct3 == F3_LD_SD) begin
					dec_rd = in_inst[11:7];
					use_rs1 = 1'b1;
					use_imm = 1'b1;
					mem_op = MEM_LOAD;
				end
			end
			OPC_STORE: begin
				// address from rs1, data from rs2
				if (funct3 == F3_LD_SD) begin
					imm = imm_s;
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
					use_imm = 1'b1;
					mem_op = MEM_STORE;
				end
			end
			OPC_BRANCH: begin
				if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
					imm = imm_b;
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
					is_branch = 1'b1;
					branch_ne = (funct3 == F3_BNE);
				end
			end
			OPC_JAL: begin
				dec_rd = in_inst[11:7];
				imm = imm_j;
				is_jal = 1'b1;
			end
			default: ;
		endcase
	end

	// ********************
	// scoreboard and stall
	// ********************
	// sources wait for writeback to finish, no forwarding
	// a busy rd may reissue in the cycle its older write retires
	assign hazard = (use_rs1 & busy[rs1_addr]) | (use_rs2 & busy[rs2_addr]) |
		((dec_rd != '0) & busy[dec_rd] & ~(wb_en & (wb_rd == dec_rd)));
	assign slot_free = ~out_valid | out_ready;
	assign in_ready = slot_free & ~hazard & ~flush;
	assign issue = in_valid & in_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= '0;
		end else begin
			if (wb_en) begin
				busy[wb_rd] <= 1'b0;
			end
			// set after clear so the set wins
			if (issue && dec_rd != '0) begin
				busy[dec_rd] <= 1'b1;
			end
		end
	end

	// ********************
	// id_ex register
	// ********************
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (flush) begin
			out_valid <= 1'b0;
		end else if (slot_free) begin
			out_valid <= issue;
		end
	end

	// payload only moves on issue
	always_ff @(posedge clk) begin
		if (issue) begin
			out_pc <= in_pc;
			out_src_a <= rs1_data;
			out_src_b <= rs2_data;
			out_imm <= imm;
			out_rd <= dec_rd;
			out_alu_op <= alu_op;
			out_mem_op <= mem_op;
			out_is_branch <= is_branch;
			out_branch_ne <= branch_ne;
			out_is_jal <= is_jal;
			out_use_imm <= use_imm;
		end
	end

endmodule

/* design/execute_unit.sv */
// execute stage with ALU, branch resolution, redirect to fetch and the ex_mem register
`timescale 1ns/10ps

module execute_unit import core_pkg::*; (
	input logic clk,
	input logic rst,
	// from decode
	input logic in_valid,
	input logic [XLEN-1:0] in_pc,
	input logic [XLEN-1:0] in_src_a,
	input logic [XLEN-1:0] in_src_b,
	input logic [XLEN-1:0] in_imm,
	input logic [REG_AW-1:0] in_rd,
	input alu_op_t in_alu_op,
	input mem_op_t in_mem_op,
	input logic in_is_branch,
	input logic in_branch_ne,
	input logic in_is_jal,
	input logic in_use_imm,
	output logic in_ready,
	// to fetch and decode
	output logic redirect,
	output logic [XLEN-1:0] redirect_pc,
	// to memory
	output logic out_valid,
	input logic out_ready,
	output logic [XLEN-1:0] out_pc,
	output logic [XLEN-1:0] out_result,
	output logic [XLEN-1:0] out_store_data,
	output logic [REG_AW-1:0] out_rd,
	output mem_op_t out_mem_op
);

	logic [XLEN-1:0] op_b, alu_out, result;
	logic take, accept;

	// ********************
	// alu
	// ********************
	// immediate replaces rs2 for OP_IMM, LUI and address calc
	assign op_b = in_use_imm ? in_imm : in_src_b;

	always_comb begin
		case (in_alu_op)
			ALU_ADD: alu_out = in_src_a + op_b;
			ALU_SUB: alu_out = in_src_a - op_b;
			ALU_AND: alu_out = in_src_a & op_b;
			ALU_OR: alu_out = in_src_a | op_b;
			ALU_XOR: alu_out = in_src_a ^ op_b;
			ALU_PASS_B: alu_out = op_b;
			default: alu_out = op_b;
		endcase
	end

	// jal links pc+4
	assign result = in_is_jal ? in_pc + XLEN'(4) : alu_out;

	// ********************
	// branch and jump
	// ********************
	// beq taken on equal, bne on not equal
	assign take = in_is_jal | (in_is_branch & ((in_src_a == in_src_b) ^ in_branch_ne));
	assign in_ready = ~out_valid | out_ready;
	assign accept = in_valid & in_ready;
	// one cycle pulse, only when the item really moves in
	assign redirect = accept & take;
	assign redirect_pc = in_pc + in_imm;

	// ex_mem register
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out_pc <= in_pc;
			out_result <= result;
			out_store_data <= in_src_b;
			out_rd <= in_rd;
			out_mem_op <= in_mem_op;
		end
	end

endmodule

/* design/fetch_unit.sv */
// fetch stage holding the pc and instruction memory and presenting one word per cycle to decode
`timescale 1ns/10ps

module fetch_unit import core_pkg::*; (
	input logic clk,
	input logic rst,
	// loader port, effective during reset only
	input logic load_en,
	input logic [$clog2(IMEM_DEPTH)-1:0] load_addr,
	input logic [ILEN-1:0] load_data,
	// from execute
	input logic redirect,
	input logic [XLEN-1:0] redirect_pc,
	// to decode
	output logic out_valid,
	input logic out_ready,
	output logic [XLEN-1:0] out_pc,
	output logic [ILEN-1:0] out_inst
);

	logic [ILEN-1:0] imem [IMEM_DEPTH];
	// low for the first cycle out of reset
	logic run;

	// ********************
	// instruction memory
	// ********************
	always_ff @(posedge clk) begin
		if (rst && load_en) begin
			imem[load_addr] <= load_data;
		end
	end

	// word at pc, read combinationally
	assign out_inst = imem[out_pc[$clog2(IMEM_DEPTH)+1:2]];

	// item withheld while a redirect is in flight
	assign out_valid = run & ~redirect;

	// ********************
	// pc update
	// ********************
	always_ff @(posedge clk) begin
		if (rst) begin
			run <= 1'b0;
			out_pc <= RESET_PC;
		end else begin
			run <= 1'b1;
			// redirect beats the pc+4 guess
			if (redirect) begin
				out_pc <= redirect_pc;
			end else if (out_valid && out_ready) begin
				out_pc <= out_pc + XLEN'(4);
			end
		end
	end

endmodule

/* design/memory_unit.sv */
// memory stage with internal doubleword data memory for LD and SD and the mem_wb register
`timescale 1ns/10ps

module memory_unit import core_pkg::*; (
	input logic clk,
	input logic rst,
	// from execute
	input logic in_valid,
	output logic in_ready,
	input logic [XLEN-1:0] in_pc,
	input logic [XLEN-1:0] in_result,
	input logic [XLEN-1:0] in_store_data,
	input logic [REG_AW-1:0] in_rd,
	input mem_op_t in_mem_op,
	// to writeback
	output logic out_valid,
	input logic out_ready,
	output logic [XLEN-1:0] out_pc,
	output logic [REG_AW-1:0] out_rd,
	output logic [XLEN-1:0] out_data
);

	logic [XLEN-1:0] dmem [DMEM_DEPTH];
	logic [$clog2(DMEM_DEPTH)-1:0] idx;
	logic accept;

	// doubleword index from the byte address
	assign idx = in_result[$clog2(DMEM_DEPTH)+2:3];

	assign in_ready = ~out_valid | out_ready;
	assign accept = in_valid & in_ready;

	// ********************
	// data memory
	// ********************
	// SD lands on the transfer edge
	always_ff @(posedge clk) begin
		if (accept && in_mem_op == MEM_STORE) begin
			dmem[idx] <= in_store_data;
		end
	end

	// ********************
	// mem_wb register
	// ********************
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	// LD data or the alu result
	always_ff @(posedge clk) begin
		if (accept) begin
			out_pc <= in_pc;
			out_rd <= in_rd;
			if (in_mem_op == MEM_LOAD) begin
				out_data <= dmem[idx];
			end else begin
				out_data <= in_result;
			end
		end
	end

endmodule

/* design/npc_core.sv */
// top of the five-stage RV64 core joining fetch, decode, execute, memory, writeback and registers
`timescale 1ns/10ps

module npc_core import core_pkg::*; (
	input logic clk,
	input logic rst,
	input logic load_en,
	input logic [$clog2(IMEM_DEPTH)-1:0] load_addr,
	input logic [ILEN-1:0] load_data,
	output logic [XLEN-1:0] pc,
	output logic retire_valid,
	output logic [XLEN-1:0] retire_pc,
	output logic [REG_AW-1:0] retire_rd,
	output logic [XLEN-1:0] retire_data
);

	// ********************
	// stage wires
	// ********************
	// if_id, pc is the top pc port
	logic if_id_valid, if_id_ready;
	logic [ILEN-1:0] if_id_inst;
	// id_ex
	logic id_ex_valid, id_ex_ready;
	logic [XLEN-1:0] id_ex_pc, id_ex_src_a, id_ex_src_b, id_ex_imm;
	logic [REG_AW-1:0] id_ex_rd;
	alu_op_t id_ex_alu_op;
	mem_op_t id_ex_mem_op;
	logic id_ex_is_branch, id_ex_branch_ne, id_ex_is_jal, id_ex_use_imm;
	// ex_mem
	logic ex_mem_valid, ex_mem_ready;
	logic [XLEN-1:0] ex_mem_pc, ex_mem_result, ex_mem_store_data;
	logic [REG_AW-1:0] ex_mem_rd;
	mem_op_t ex_mem_mem_op;
	// mem_wb
	logic mem_wb_valid, mem_wb_ready;
	logic [XLEN-1:0] mem_wb_pc, mem_wb_data;
	logic [REG_AW-1:0] mem_wb_rd;
	// redirect, register file, writeback
	logic redirect;
	logic [XLEN-1:0] redirect_pc;
	logic [REG_AW-1:0] rs1_addr, rs2_addr, wb_rd;
	logic [XLEN-1:0] rs1_data, rs2_data, wb_data;
	logic wb_en;

	fetch_unit u_fetch (
		.clk(clk), .rst(rst), .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.out_valid(if_id_valid), .out_ready(if_id_ready), .out_pc(pc), .out_inst(if_id_inst)
	);

	decode_unit u_decode (
		.clk(clk), .rst(rst), .in_valid(if_id_valid), .in_ready(if_id_ready), .in_pc(pc),
		.in_inst(if_id_inst), .rs1_addr(rs1_addr), .rs1_data(rs1_data), .rs2_addr(rs2_addr),
		.rs2_data(rs2_data), .wb_en(wb_en), .wb_rd(wb_rd), .flush(redirect),
		.out_valid(id_ex_valid), .out_ready(id_ex_ready), .out_pc(id_ex_pc),
		.out_src_a(id_ex_src_a), .out_src_b(id_ex_src_b), .out_imm(id_ex_imm),
		.out_rd(id_ex_rd), .out_alu_op(id_ex_alu_op), .out_mem_op(id_ex_mem_op),
		.out_is_branch(id_ex_is_branch), .out_branch_ne(id_ex_branch_ne),
		.out_is_jal(id_ex_is_jal), .out_use_imm(id_ex_use_imm)
	);

	execute_unit u_execute (
		.clk(clk), .rst(rst), .in_valid(id_ex_valid), .in_pc(id_ex_pc),
		.in_src_a(id_ex_src_a), .in_src_b(id_ex_src_b), .in_imm(id_ex_imm), .in_rd(id_ex_rd),
		.in_alu_op(id_ex_alu_op), .in_mem_op(id_ex_mem_op), .in_is_branch(id_ex_is_branch),
		.in_branch_ne(id_ex_branch_ne), .in_is_jal(id_ex_is_jal), .in_use_imm(id_ex_use_imm),
		.in_ready(id_ex_ready), .redirect(redirect), .redirect_pc(redirect_pc),
		.out_valid(ex_mem_valid), .out_ready(ex_mem_ready), .out_pc(ex_mem_pc),
		.out_result(ex_mem_result), .out_store_data(ex_mem_store_data), .out_rd(ex_mem_rd),
		.out_mem_op(ex_mem_mem_op)
	);

	memory_unit u_memory (
		.clk(clk), .rst(rst), .in_valid(ex_mem_valid), .in_ready(ex_mem_ready),
		.in_pc(ex_mem_pc), .in_result(ex_mem_result), .in_store_data(ex_mem_store_data),
		.in_rd(ex_mem_rd), .in_mem_op(ex_mem_mem_op), .out_valid(mem_wb_valid),
		.out_ready(mem_wb_ready), .out_pc(mem_wb_pc), .out_rd(mem_wb_rd), .out_data(mem_wb_data)
	);

	writeback_unit u_writeback (
		.clk(clk), .rst(rst), .in_valid(mem_wb_valid), .in_ready(mem_wb_ready),
		.in_pc(mem_wb_pc), .in_rd(mem_wb_rd), .in_data(mem_wb_data), .wb_en(wb_en),
		.wb_rd(wb_rd), .wb_data(wb_data), .retire_valid(retire_valid), .retire_pc(retire_pc),
		.retire_rd(retire_rd), .retire_data(retire_data)
	);

	register_file u_regs (
		.clk(clk), .rs1_addr(rs1_addr), .rs1_data(rs1_data), .rs2_addr(rs2_addr),
		.rs2_data(rs2_data), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
	);

endmodule

/* design/register_file.sv */
// general register file of the core with two reads for decode and one write from writeback
`timescale 1ns/10ps

module register_file import core_pkg::*; (
	input logic clk,
	input logic [REG_AW-1:0] rs1_addr,
	output logic [XLEN-1:0] rs1_data,
	input logic [REG_AW-1:0] rs2_addr,
	output logic [XLEN-1:0] rs2_data,
	input logic wb_en,
	input logic [REG_AW-1:0] wb_rd,
	input logic [XLEN-1:0] wb_data
);

	// storage, x0 slot never written
	logic [XLEN-1:0] regs [NREG];

	// single write port
	always_ff @(posedge clk) begin
		if (wb_en && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// combinational reads
	// same-cycle write shows up only on the next cycle
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* design/writeback_unit.sv */
// writeback stage driving the register file write, busy clear and the retire port
`timescale 1ns/10ps

module writeback_unit import core_pkg::*; (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input logic [XLEN-1:0] in_pc,
	input logic [REG_AW-1:0] in_rd,
	input logic [XLEN-1:0] in_data,
	output logic wb_en,
	output logic [REG_AW-1:0] wb_rd,
	output logic [XLEN-1:0] wb_data,
	output logic retire_valid,
	output logic [XLEN-1:0] retire_pc,
	output logic [REG_AW-1:0] retire_rd,
	output logic [XLEN-1:0] retire_data
);

	// last stage never back-pressures
	assign in_ready = 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			retire_pc <= in_pc;
			retire_rd <= in_rd;
			retire_data <= in_data;
		end
	end

	// no write for x0 or empty slot
	assign wb_en = retire_valid & (retire_rd != '0);
	assign wb_rd = retire_rd;
	assign wb_data = retire_data;

endmodule

/* sim/tb_core.sv */
// directed testbench for the core, loads each program during reset and checks the retire stream
`timescale 1ns/10ps

module tb_core import core_pkg::*; ();

	logic clk;
	logic rst;
	logic load_en;
	logic [$clog2(IMEM_DEPTH)-1:0] load_addr;
	logic [ILEN-1:0] load_data;
	logic [XLEN-1:0] pc;
	logic retire_valid;
	logic [XLEN-1:0] retire_pc;
	logic [REG_AW-1:0] retire_rd;
	logic [XLEN-1:0] retire_data;

	// program words and expected retire stream of the current test
	logic [31:0] prog [$];
	logic [63:0] exp_pc [$];
	logic [63:0] exp_rd [$];
	logic [63:0] exp_data [$];
	// what the monitor saw
	logic [63:0] ret_pc [$];
	logic [63:0] ret_rd [$];
	logic [63:0] ret_data [$];

	npc_core dut (
		.clk(clk), .rst(rst), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .pc(pc), .retire_valid(retire_valid),
		.retire_pc(retire_pc), .retire_rd(retire_rd), .retire_data(retire_data)
	);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// retire monitor, sampled mid-cycle where outputs are settled
	always @(negedge clk) begin
		if (!rst && retire_valid) begin
			ret_pc.push_back(retire_pc);
			ret_rd.push_back(64'(retire_rd));
			ret_data.push_back(retire_data);
		end
	end

	// ********************
	// instruction encoding
	// ********************
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
		input int rd, input int rs1, input int rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
		input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
	endfunction

	function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
		return i_type(OPC_OP_IMM, F3_ADD, rd, rs1, imm);
	endfunction

	// sd rs2, imm(rs1)
	function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], F3_LD_SD, imm[4:0], OPC_STORE};
	endfunction

	// branch offset bit 0 is implicit
	function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1, input int rs2,
		input int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input int rd, input int imm20);
		return {imm20[19:0], rd[4:0], OPC_LUI};
	endfunction

	function automatic logic [31:0] j_type(input int rd, input int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
	endfunction

	// RV64 sign extension of a 32-bit value
	function automatic logic [63:0] sext(input int v);
		return {{32{v[31]}}, v};
	endfunction

	// ********************
	// checks and failure
	// ********************
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input string label, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", label, expected, actual);
			fail_run("stopping at the first mismatch");
		end
	endtask

	task automatic new_program();
		prog.delete();
		exp_pc.delete();
		exp_rd.delete();
		exp_data.delete();
	endtask

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
	endtask

	task automatic expect_retire(input int at_pc, input int rd, input logic [63:0] data);
		exp_pc.push_back(64'(at_pc));
		exp_rd.push_back(64'(rd));
		exp_data.push_back(data);
	endtask

	// 16 reset cycles, one program word per cycle
	task automatic reset_and_load(input string name);
		@(posedge clk);
		#2;
		rst = 1'b1;
		ret_pc.delete();
		ret_rd.delete();
		ret_data.delete();
		for (int i = 0; i < 16; i++) begin
			load_en = 1'b1;
			load_addr = i[7:0];
			// spare words are addi x0 no-ops carrying their own index
			load_data = (i < prog.size()) ? prog[i] : addi(0, 0, i);
			@(posedge clk);
			#2;
		end
		// fetch sits at the reset vector, address 0
		check_value($sformatf("%s reset pc", name), 64'd0, pc);
		rst = 1'b0;
		load_en = 1'b0;
	endtask

	task automatic wait_retires(input string name, input int count, input int limit);
		int cycles;
		cycles = 0;
		while (ret_pc.size() < count) begin
			if (cycles >= limit) begin
				fail_run($sformatf("timeout in %s: %0d retires expected, %0d seen after %0d cycles",
					name, count, ret_pc.size(), limit));
			end else begin
				@(posedge clk);
				cycles++;
			end
		end
	endtask

	// rd 0 items carry no architectural value
	task automatic compare_retires(input string name);
		for (int i = 0; i < exp_pc.size(); i++) begin
			check_value($sformatf("%s retire %0d pc", name, i), exp_pc[i], ret_pc[i]);
			check_value($sformatf("%s retire %0d rd", name, i), exp_rd[i], ret_rd[i]);
			if (exp_rd[i] != 64'd0) begin
				check_value($sformatf("%s retire %0d data", name, i), exp_data[i], ret_data[i]);
			end
		end
	endtask

	task automatic run_program(input string name);
		reset_and_load(name);
		wait_retires(name, exp_pc.size(), 400);
		compare_retires(name);
	endtask

	task automatic check_never_retired(input string name, input int skipped_pc);
		int hits;
		hits = 0;
		foreach (ret_pc[k]) begin
			if (ret_pc[k] == 64'(skipped_pc)) begin
				hits++;
			end
		end
		check_value($sformatf("%s retires of pc %0d", name, skipped_pc), 64'd0, 64'(hits));
	endtask

	// ********************
	// directed tests
	// ********************
	// each op reads the one before, so every step stalls on the scoreboard
	task automatic alu_chain();
		logic [63:0] v1, v2, v3, v4, v5, v6, v7;
		new_program();
		emit(addi(1, 0, 1443));
		emit(addi(5, 0, 240));
		emit(r_type(7'd0, F3_ADD, 2, 1, 1));
		emit(r_type(F7_SUB, F3_ADD, 3, 5, 2));
		emit(r_type(7'd0, F3_XOR, 4, 3, 1));
		emit(r_type(7'd0, F3_OR, 6, 4, 5));
		emit(r_type(7'd0, F3_AND, 7, 6, 3));
		emit(j_type(0, 0));
		v1 = sext(1443);
		v5 = sext(240);
		v2 = v1 + v1;
		// goes negative
		v3 = v5 - v2;
		v4 = v3 ^ v1;
		v6 = v4 | v5;
		v7 = v6 & v3;
		expect_retire(0, 1, v1);
		expect_retire(4, 5, v5);
		expect_retire(8, 2, v2);
		expect_retire(12, 3, v3);
		expect_retire(16, 4, v4);
		expect_retire(20, 6, v6);
		expect_retire(24, 7, v7);
		run_program("alu_chain");
	endtask

	task automatic lui_immediates();
		new_program();
		emit(u_type(1, 32'h12345));
		emit(u_type(2, 32'hfffff));
		emit(addi(3, 1, -1));
		emit(addi(4, 0, -2048));
		emit(addi(5, 2, -5));
		emit(j_type(0, 0));
		expect_retire(0, 1, sext(32'h12345 << 12));
		expect_retire(4, 2, sext(32'hfffff << 12));
		expect_retire(8, 3, sext(32'h12345 << 12) + sext(-1));
		expect_retire(12, 4, sext(-2048));
		expect_retire(16, 5, sext(32'hfffff << 12) + sext(-5));
		run_program("lui_immediates");
	endtask

	// stores in one order, loads back in another
	task automatic store_load();
		logic [63:0] a, b, c;
		new_program();
		emit(addi(1, 0, 291));
		emit(u_type(2, 32'h80000));
		emit(addi(3, 0, -7));
		emit(addi(10, 0, 64));
		emit(s_type(1, 10, 0));
		emit(s_type(2, 10, 8));
		emit(s_type(3, 10, 24));
		emit(i_type(OPC_LOAD, F3_LD_SD, 4, 10, 24));
		emit(i_type(OPC_LOAD, F3_LD_SD, 5, 10, 0));
		emit(i_type(OPC_LOAD, F3_LD_SD, 6, 10, 8));
		emit(j_type(0, 0));
		a = sext(291);
		b = sext(32'h80000 << 12);
		c = sext(-7);
		expect_retire(0, 1, a);
		expect_retire(4, 2, b);
		expect_retire(8, 3, c);
		expect_retire(12, 10, sext(64));
		expect_retire(16, 0, '0);
		expect_retire(20, 0, '0);
		expect_retire(24, 0, '0);
		expect_retire(28, 4, c);
		expect_retire(32, 5, a);
		expect_retire(36, 6, b);
		run_program("store_load");
	endtask

	task automatic branches();
		new_program();
		emit(addi(1, 0, 7));
		emit(addi(2, 0, 7));
		// taken beq to 20
		emit(b_type(F3_BEQ, 1, 2, 12));
		emit(addi(3, 0, 1));
		emit(addi(3, 0, 2));
		// bne on equal falls through
		emit(b_type(F3_BNE, 1, 2, 8));
		emit(addi(4, 0, 3));
		emit(addi(5, 0, 9));
		// taken bne to 44
		emit(b_type(F3_BNE, 1, 5, 12));
		emit(addi(6, 0, 1));
		emit(addi(6, 0, 2));
		emit(b_type(F3_BEQ, 1, 5, 8));
		emit(addi(7, 0, 5));
		emit(j_type(0, 0));
		expect_retire(0, 1, sext(7));
		expect_retire(4, 2, sext(7));
		expect_retire(8, 0, '0);
		expect_retire(20, 0, '0);
		expect_retire(24, 4, sext(3));
		expect_retire(28, 5, sext(9));
		expect_retire(32, 0, '0);
		expect_retire(44, 0, '0);
		expect_retire(48, 7, sext(5));
		run_program("branches");
		// let the end loop spin a while, then look for shadow items
		wait_retires("branches", exp_pc.size() + 6, 400);
		check_never_retired("branches", 12);
		check_never_retired("branches", 16);
		check_never_retired("branches", 36);
		check_never_retired("branches", 40);
	endtask

	// link value is read right after the jump lands
	task automatic jal_link();
		new_program();
		emit(addi(1, 0, 11));
		emit(j_type(5, 12));
		emit(addi(1, 0, 99));
		emit(addi(1, 0, 98));
		emit(r_type(7'd0, F3_ADD, 6, 5, 1));
		emit(j_type(0, 0));
		expect_retire(0, 1, sext(11));
		expect_retire(4, 5, 64'd8);
		expect_retire(16, 6, 64'd8 + sext(11));
		run_program("jal_link");
	endtask

	task automatic x0_writes();
		new_program();
		emit(addi(0, 0, 123));
		emit(r_type(7'd0, F3_ADD, 1, 0, 0));
		emit(addi(2, 0, 42));
		emit(r_type(7'd0, F3_OR, 3, 0, 2));
		emit(j_type(0, 0));
		expect_retire(0, 0, '0);
		expect_retire(4, 1, 64'd0);
		expect_retire(8, 2, sext(42));
		expect_retire(12, 3, sext(42));
		run_program("x0_writes");
	endtask

	initial begin
		rst = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		alu_chain();
		lui_immediates();
		store_load();
		branches();
		jal_link();
		x0_writes();
		$display("All checks passed");
		$finish;
	end

endmodule
